/* data_cache_vectors.txt */
// op byte_op address data_in expected_data expected_hit (hex, one access per line)
// op 1 = read, 0 = write; expected data is compared on reads only
1 0 00001000 00000000 5a5a1000 0
1 0 00001000 00000000 5a5a1000 1
1 0 00001004 00000000 5a5a1004 1
0 0 00001008 11223344 11223344 1
1 0 00001008 00000000 11223344 1
0 1 00001009 000000ab 000000ab 1
1 1 00001009 00000000 000000ab 1
1 1 0000100b 00000000 00000011 1
1 0 00001008 00000000 1122ab44 1
0 0 00002004 cafe0001 cafe0001 0
1 0 00002004 00000000 cafe0001 1
1 0 00002000 00000000 5a5a2000 1
1 0 00002008 00000000 5a5a2008 1
1 0 0000200c 00000000 5a5a200c 1
1 0 00003000 00000000 5a5a3000 0
1 0 00004000 00000000 5a5a4000 0
1 0 00001000 00000000 5a5a1000 1
1 0 00005000 00000000 5a5a5000 0
1 0 00001008 00000000 1122ab44 1
1 0 00002004 00000000 cafe0001 0
1 0 00002000 00000000 5a5a2000 1
1 0 00003000 00000000 5a5a3000 0
1 0 00004000 00000000 5a5a4000 0
1 0 00001008 00000000 1122ab44 1
0 1 00003002 00000077 00000077 1
1 1 00003002 00000000 00000077 1
1 0 00003000 00000000 5a773000 1
1 0 00006000 00000000 5a5a6000 0
0 0 00007000 0badf00d 0badf00d 0
1 0 00008000 00000000 5a5a8000 0
1 0 00001008 00000000 1122ab44 0
1 0 00003000 00000000 5a773000 0
1 0 00007000 00000000 0badf00d 1
1 1 00007003 00000000 0000000b 1
1 0 00007004 00000000 5a5a7004 1
1 0 00007008 00000000 5a5a7008 1
1 0 0000700c 00000000 5a5a700c 1
1 1 00009001 00000000 00000090 0

/* build.f */
cache_pkg.sv
cache_lookup.sv
cache_lru.sv
cache_controller.sv
cache_read_format.sv
data_cache.sv
data_cache_properties.sv
tb_data_cache.sv

/* Bender.yml */
package:
  name: data_cache

sources:
  - cache_pkg.sv
  - cache_lookup.sv
  - cache_lru.sv
  - cache_controller.sv
  - cache_read_format.sv
  - data_cache.sv
  - target: test
    files:
      - data_cache_properties.sv
      - tb_data_cache.sv

/* tb_data_cache.sv */
// Data cache testbench
`default_nettype none

module tb_data_cache
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t PATTERN_KEY = 32'h5a5a0000;
  localparam int CYCLES_PER_VECTOR = 40;
  localparam int HIT_LATENCY = 3;

  logic     clk;
  logic     reset;
  logic     access;
  logic     op;
  logic     byte_op;
  address_t address;
  word_t    data_in;
  word_t    data_out;
  logic     hit;
  logic     data_ready;
  logic     mem_enable;
  logic     mem_op;
  address_t mem_address;
  line_t    mem_data_in;
  line_t    mem_data_out;
  logic     mem_data_ready;

  // One queue per vector column
  logic     vec_op [$];
  logic     vec_byte_op [$];
  address_t vec_address [$];
  word_t    vec_data [$];
  word_t    vec_expected [$];
  logic     vec_hit [$];
  logic     load_done = 1'b0;

  // Memory model lines, and the latest word the core wrote at each address
  line_t mem_lines [address_t];
  word_t ref_words [address_t];

  int checks = 0;
  int errors = 0;
  int writebacks = 0;
  int refills = 0;
  logic [31:0] lfsr;

  data_cache data_cache_inst (
    .clk            (clk),
    .reset          (reset),
    .access         (access),
    .op             (op),
    .byte_op        (byte_op),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .hit            (hit),
    .data_ready     (data_ready),
    .mem_enable     (mem_enable),
    .mem_op         (mem_op),
    .mem_address    (mem_address),
    .mem_data_in    (mem_data_in),
    .mem_data_out   (mem_data_out),
    .mem_data_ready (mem_data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Untouched memory word, unique for every address
  function automatic word_t pattern_word(address_t word_address);
    return word_address ^ PATTERN_KEY;
  endfunction

  function automatic line_t read_line(address_t line_address);
    line_t line;
    if (mem_lines.exists(line_address))
    begin
      return mem_lines[line_address];
    end
    for (int w = 0; w < WORDS_PER_LINE; w++)
    begin
      line[w*WORD_WIDTH +: WORD_WIDTH] = pattern_word(line_address + address_t'(4 * w));
    end
    return line;
  endfunction

  // What a written back word has to hold
  function automatic word_t expected_word(address_t word_address);
    if (ref_words.exists(word_address))
    begin
      return ref_words[word_address];
    end
    return pattern_word(word_address);
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic random_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | lfsr[0];
    end
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Word or single lane update of the reference copy
  task automatic record_write(input logic is_byte, input address_t byte_address,
                              input word_t value);
    address_t word_address;
    word_t word;
    word_address = {byte_address[ADDRESS_WIDTH-1:2], 2'b00};
    word = expected_word(word_address);
    if (is_byte)
    begin
      word[byte_address[1:0]*8 +: 8] = value[7:0];
    end
    else
    begin
      word = value;
    end
    ref_words[word_address] = word;
  endtask

  // Line memory, answers after 0 to 3 idle cycles
  initial
  begin : memory_model
    address_t line_address;
    int wait_cycles;
    logic busy;
    mem_data_ready = 1'b0;
    mem_data_out = '0;
    lfsr = 32'hbe56;
    busy = 1'b0;
    wait_cycles = 0;
    forever
    begin
      @(posedge clk);
      if (mem_data_ready)
      begin
        mem_data_ready <= 1'b0;
      end
      else if (mem_enable)
      begin
        if (!busy)
        begin
          busy = 1'b1;
          random_bits(2, wait_cycles);
        end
        if (wait_cycles == 0)
        begin
          busy = 1'b0;
          line_address = {mem_address[ADDRESS_WIDTH-1:4], 4'h0};
          // Both writebacks and refills use line aligned addresses
          check_value("memory address low bits", mem_address[3:0], 0);
          if (mem_op)
          begin
            // Evicted line must carry every word the core wrote
            for (int w = 0; w < WORDS_PER_LINE; w++)
            begin
              check_value($sformatf("writeback word at %h", line_address + 4 * w),
                          mem_data_in[w*WORD_WIDTH +: WORD_WIDTH],
                          expected_word(line_address + address_t'(4 * w)));
            end
            mem_lines[line_address] = mem_data_in;
            writebacks++;
          end
          else
          begin
            mem_data_out <= read_line(line_address);
            refills++;
          end
          mem_data_ready <= 1'b1;
        end
        else
        begin
          wait_cycles--;
        end
      end
    end
  end

  initial
  begin : stimulus
    int fd;
    int code;
    int fields;
    string text;
    word_t f_op;
    word_t f_byte;
    word_t f_addr;
    word_t f_data;
    word_t f_exp;
    word_t f_hit;
    int cycles;
    int wb_start;
    int rd_start;
    logic done;
    reset = 1'b1;
    access = 1'b0;
    op = 1'b0;
    byte_op = 1'b0;
    address = '0;
    data_in = '0;

    fd = $fopen("data_cache_vectors.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the vector file data_cache_vectors.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(text, fd);
        // Comment and blank lines give fewer than six fields
        fields = (code > 0) ? $sscanf(text, "%h %h %h %h %h %h",
                                      f_op, f_byte, f_addr, f_data, f_exp, f_hit) : 0;
        if (fields == 6)
        begin
          vec_op.push_back(f_op[0]);
          vec_byte_op.push_back(f_byte[0]);
          vec_address.push_back(f_addr);
          vec_data.push_back(f_data);
          vec_expected.push_back(f_exp);
          vec_hit.push_back(f_hit[0]);
        end
      end
      $fclose(fd);
    end
    if (vec_op.size() == 0)
    begin
      errors++;
      $display("No test vectors were loaded");
    end
    load_done = 1'b1;

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("data_ready after reset", data_ready, 0);
    check_value("mem_enable after reset", mem_enable, 0);
    check_value("mem_op after reset", mem_op, 0);
    check_value("hit after reset", hit, 0);

    for (int i = 0; i < vec_op.size(); i++)
    begin
      @(posedge clk);
      access <= 1'b1;
      op <= vec_op[i];
      byte_op <= vec_byte_op[i];
      address <= vec_address[i];
      data_in <= vec_data[i];
      if (vec_op[i] == OP_WRITE)
      begin
        record_write(vec_byte_op[i], vec_address[i], vec_data[i]);
      end
      wb_start = writebacks;
      rd_start = refills;
      // Edge that samples access
      @(posedge clk);
      access <= 1'b0;
      cycles = 0;
      done = 1'b0;
      while (!done)
      begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
        done = data_ready;
      end
      if (vec_op[i] == OP_READ)
      begin
        check_value($sformatf("read data, vector %0d", i), data_out, vec_expected[i]);
      end
      check_value($sformatf("hit flag, vector %0d", i), hit, vec_hit[i]);
      if (vec_hit[i])
      begin
        check_value($sformatf("hit latency, vector %0d", i), cycles, HIT_LATENCY);
        check_value($sformatf("refills on hit, vector %0d", i), refills - rd_start, 0);
        check_value($sformatf("writebacks on hit, vector %0d", i), writebacks - wb_start, 0);
      end
      else
      begin
        check_value($sformatf("refills on miss, vector %0d", i), refills - rd_start, 1);
        check_value($sformatf("at most one writeback, vector %0d", i),
                    (writebacks - wb_start) <= 1, 1);
      end
    end

    if (writebacks == 0)
    begin
      errors++;
      $display("No dirty line was written back to memory during the run");
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Run length scales with the vector count
  initial
  begin : watchdog
    wait (load_done);
    repeat (vec_op.size() * CYCLES_PER_VECTOR + 20) @(posedge clk);
    $display("Timeout: the cache stopped answering before all vectors were done");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* data_cache_properties.sv */
// Data cache handshake assertions
`default_nettype none

module data_cache_properties
  import cache_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input logic         access,
  input logic         data_ready,
  input logic         hit,
  input logic         mem_enable,
  input logic         mem_op,
  input address_t     mem_address,
  input line_t        mem_data_in,
  input logic         mem_data_ready,
  input cache_state_t state
);

  timeunit 1ns;
  timeprecision 1ps;

  // Core may only start a request while the FSM is idle
  access_only_in_idle: assert property (
    @(posedge clk) disable iff (reset)
    access |-> state == IDLE
  ) else $error("access raised while the cache controller was busy");

  // Result handshake is a single cycle pulse
  data_ready_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    data_ready |=> !data_ready
  ) else $error("data_ready stayed high for more than one cycle");

  // Request toward memory holds until memory answers
  mem_request_stable: assert property (
    @(posedge clk) disable iff (reset)
    mem_enable && !mem_data_ready |=>
      mem_enable && $stable(mem_op) && $stable(mem_address) && $stable(mem_data_in)
  ) else $error("memory request changed before mem_data_ready");

  // Enable drops right after the answer
  mem_enable_release: assert property (
    @(posedge clk) disable iff (reset)
    mem_enable && mem_data_ready |=> !mem_enable
  ) else $error("mem_enable stayed high after mem_data_ready");

  // Hit path is LOOKUP, UPDATE, RESPOND
  // data_ready rises 3 edges after access and is sampled high one edge later
  hit_latency: assert property (
    @(posedge clk) disable iff (reset)
    data_ready && hit |-> $past(access, 4)
  ) else $error("hit response did not arrive 3 cycles after access");

endmodule

bind data_cache data_cache_properties data_cache_properties_inst (
  .clk            (clk),
  .reset          (reset),
  .access         (access),
  .data_ready     (data_ready),
  .hit            (hit),
  .mem_enable     (mem_enable),
  .mem_op         (mem_op),
  .mem_address    (mem_address),
  .mem_data_in    (mem_data_in),
  .mem_data_ready (mem_data_ready),
  .state          (cache_controller_inst.state)
);

`default_nettype wire

/* data_cache.sv */
// Data cache top level
`default_nettype none

module data_cache
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // Core side
  input  logic     access,
  input  logic     op,
  input  logic     byte_op,
  input  address_t address,
  input  word_t    data_in,
  output word_t    data_out,
  output logic     hit,
  output logic     data_ready,
  // Memory side
  output logic     mem_enable,
  output logic     mem_op,
  output address_t mem_address,
  output line_t    mem_data_in,
  input  line_t    mem_data_out,
  input  logic     mem_data_ready
);

  // Lookup results on the registered request
  address_t     req_address;
  tag_t         stored_tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid_lines;
  logic         lookup_hit;
  line_index_t  hit_line;
  tag_t         tag;
  word_offset_t word_offset;
  byte_offset_t byte_offset;

  // LRU
  logic         touch;
  line_index_t  touch_line;
  line_index_t  victim_line;

  // Result stage
  logic         respond;
  word_t        resp_word;
  logic         resp_hit;
  logic         req_byte_op;

  cache_lookup cache_lookup_inst (
    .address     (req_address),
    .stored_tags (stored_tags),
    .valid_lines (valid_lines),
    .lookup_hit  (lookup_hit),
    .hit_line    (hit_line),
    .tag         (tag),
    .word_offset (word_offset),
    .byte_offset (byte_offset)
  );

  cache_lru cache_lru_inst (
    .clk         (clk),
    .reset       (reset),
    .touch       (touch),
    .touch_line  (touch_line),
    .victim_line (victim_line)
  );

  cache_controller cache_controller_inst (
    .clk            (clk),
    .reset          (reset),
    .access         (access),
    .op             (op),
    .byte_op        (byte_op),
    .address        (address),
    .data_in        (data_in),
    .lookup_hit     (lookup_hit),
    .hit_line       (hit_line),
    .tag            (tag),
    .word_offset    (word_offset),
    .byte_offset    (byte_offset),
    .victim_line    (victim_line),
    .mem_data_out   (mem_data_out),
    .mem_data_ready (mem_data_ready),
    .req_address    (req_address),
    .stored_tags    (stored_tags),
    .valid_lines    (valid_lines),
    .touch          (touch),
    .touch_line     (touch_line),
    .mem_enable     (mem_enable),
    .mem_op         (mem_op),
    .mem_address    (mem_address),
    .mem_data_in    (mem_data_in),
    .respond        (respond),
    .resp_word      (resp_word),
    .resp_hit       (resp_hit),
    .req_byte_op    (req_byte_op)
  );

  // Byte select follows the registered request, not the live core inputs
  cache_read_format cache_read_format_inst (
    .clk         (clk),
    .reset       (reset),
    .respond     (respond),
    .resp_word   (resp_word),
    .resp_hit    (resp_hit),
    .byte_op     (req_byte_op),
    .byte_offset (byte_offset),
    .data_out    (data_out),
    .hit         (hit),
    .data_ready  (data_ready)
  );

endmodule

`default_nettype wire

/* cache_read_format.sv */
// Cache result formatting
`default_nettype none

module cache_read_format
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         respond,
  input  word_t        resp_word,
  input  logic         resp_hit,
  input  logic         byte_op,
  input  byte_offset_t byte_offset,
  output word_t        data_out,
  output logic         hit,
  output logic         data_ready
);

  // Addressed byte, zero extended
  word_t byte_word;

  assign byte_word = {{(WORD_WIDTH-8){1'b0}}, resp_word[byte_offset*8 +: 8]};

  // Handshake and hit flag
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      data_ready <= 1'b0;
      hit <= 1'b0;
    end
    else
    begin
      // One cycle pulse per respond strobe
      data_ready <= respond;
      if (respond)
      begin
        hit <= resp_hit;
      end
    end
  end

  // Result word holds until the next response
  always_ff @(posedge clk)
  begin
    if (respond)
    begin
      data_out <= byte_op ? byte_word : resp_word;
    end
  end

endmodule

`default_nettype wire

/* cache_controller.sv */
// Cache controller and storage arrays
`default_nettype none

module cache_controller
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // Core request
  input  logic         access,
  input  logic         op,
  input  logic         byte_op,
  input  address_t     address,
  input  word_t        data_in,
  // From lookup
  input  logic         lookup_hit,
  input  line_index_t  hit_line,
  input  tag_t         tag,
  input  word_offset_t word_offset,
  input  byte_offset_t byte_offset,
  // From LRU
  input  line_index_t  victim_line,
  // From memory
  input  line_t        mem_data_out,
  input  logic         mem_data_ready,
  // To lookup
  output address_t     req_address,
  output tag_t         stored_tags [NUM_LINES],
  output logic [NUM_LINES-1:0] valid_lines,
  // To LRU
  output logic         touch,
  output line_index_t  touch_line,
  // To memory
  output logic         mem_enable,
  output logic         mem_op,
  output address_t     mem_address,
  output line_t        mem_data_in,
  // To result stage
  output logic         respond,
  output word_t        resp_word,
  output logic         resp_hit,
  output logic         req_byte_op
);

  cache_state_t state;

  // Storage arrays
  tag_t  tag_array [NUM_LINES];
  line_t data_array [NUM_LINES];
  logic [NUM_LINES-1:0] dirty_lines;

  // Registered request
  logic  req_op;
  word_t req_data;

  // Line chosen in LOOKUP, hit line or victim
  line_index_t sel_line;

  // Addressed word of the selected line, before and after the write merge
  word_t cur_word;
  word_t merged_word;

  assign stored_tags = tag_array;

  assign cur_word = data_array[sel_line][word_offset*WORD_WIDTH +: WORD_WIDTH];

  always_comb
  begin
    merged_word = cur_word;
    if (req_byte_op)
    begin
      // Only the addressed lane takes the low byte of the write data
      merged_word[byte_offset*8 +: 8] = req_data[7:0];
    end
    else
    begin
      merged_word = req_data;
    end
  end

  // Every completed access counts as a use of its line
  assign touch = (state == UPDATE);
  assign touch_line = sel_line;
  assign respond = (state == RESPOND);

  // FSM, valid and dirty bits, memory handshake
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
      valid_lines <= '0;
      dirty_lines <= '0;
      mem_enable <= 1'b0;
      mem_op <= 1'b0;
      resp_hit <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (access)
          begin
            state <= LOOKUP;
          end
        end
        LOOKUP:
        begin
          resp_hit <= lookup_hit;
          if (lookup_hit)
          begin
            state <= UPDATE;
          end
          // Dirty victim goes back to memory before the refill
          else if (valid_lines[victim_line] && dirty_lines[victim_line])
          begin
            state <= WRITEBACK;
          end
          else
          begin
            state <= REFILL;
          end
        end
        WRITEBACK:
        begin
          if (!mem_enable)
          begin
            mem_enable <= 1'b1;
            mem_op <= 1'b1;
          end
          else if (mem_data_ready)
          begin
            // Drop enable so REFILL starts with a gap cycle
            mem_enable <= 1'b0;
            mem_op <= 1'b0;
            dirty_lines[sel_line] <= 1'b0;
            state <= REFILL;
          end
        end
        REFILL:
        begin
          if (!mem_enable)
          begin
            mem_enable <= 1'b1;
            mem_op <= 1'b0;
          end
          else if (mem_data_ready)
          begin
            mem_enable <= 1'b0;
            valid_lines[sel_line] <= 1'b1;
            dirty_lines[sel_line] <= 1'b0;
            state <= UPDATE;
          end
        end
        UPDATE:
        begin
          if (req_op == OP_WRITE)
          begin
            dirty_lines[sel_line] <= 1'b1;
          end
          state <= RESPOND;
        end
        RESPOND:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Request capture, line data, tags and memory payload
  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
      begin
        if (access)
        begin
          req_address <= address;
          req_op <= op;
          req_byte_op <= byte_op;
          req_data <= data_in;
        end
      end
      LOOKUP:
      begin
        sel_line <= lookup_hit ? hit_line : victim_line;
      end
      WRITEBACK:
      begin
        // Victim line address is rebuilt from its stored tag
        if (!mem_enable)
        begin
          mem_address <= {tag_array[sel_line], {(WORD_OFFSET_WIDTH+BYTE_OFFSET_WIDTH){1'b0}}};
          mem_data_in <= data_array[sel_line];
        end
      end
      REFILL:
      begin
        if (!mem_enable)
        begin
          mem_address <= {tag, {(WORD_OFFSET_WIDTH+BYTE_OFFSET_WIDTH){1'b0}}};
        end
        else if (mem_data_ready)
        begin
          data_array[sel_line] <= mem_data_out;
          tag_array[sel_line] <= tag;
        end
      end
      UPDATE:
      begin
        if (req_op == OP_WRITE)
        begin
          data_array[sel_line][word_offset*WORD_WIDTH +: WORD_WIDTH] <= merged_word;
        end
        // Reads return the stored word, writes the merged one
        resp_word <= (req_op == OP_READ) ? cur_word : merged_word;
      end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* cache_lru.sv */
// LRU replacement tracker
`default_nettype none

module cache_lru
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        touch,
  input  line_index_t touch_line,
  output line_index_t victim_line
);

  // Age of each line, NUM_LINES-1 is the most recent
  lru_count_t lru_count [NUM_LINES];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // Ages start at the line index so line 0 goes first
      for (int i = 0; i < NUM_LINES; i++)
      begin
        lru_count[i] <= lru_count_t'(i);
      end
    end
    else if (touch)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        if (line_index_t'(i) == touch_line)
        begin
          lru_count[i] <= lru_count_t'(NUM_LINES - 1);
        end
        // Lines newer than the touched one age by one
        else if (lru_count[i] > lru_count[touch_line])
        begin
          lru_count[i] <= lru_count[i] - 1'b1;
        end
      end
    end
  end

  // Ages stay a permutation, so exactly one line sits at zero
  always_comb
  begin
    victim_line = '0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      if (lru_count[i] == '0)
      begin
        victim_line = line_index_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* cache_lookup.sv */
// Cache tag lookup
`default_nettype none

module cache_lookup
  import cache_pkg::*;
(
  input  address_t     address,
  input  tag_t         stored_tags [NUM_LINES],
  input  logic [NUM_LINES-1:0] valid_lines,
  output logic         lookup_hit,
  output line_index_t  hit_line,
  output tag_t         tag,
  output word_offset_t word_offset,
  output byte_offset_t byte_offset
);

  // One match flag per line
  logic [NUM_LINES-1:0] match;

  // Address fields, tag on top, byte lane at the bottom
  assign tag = address[ADDRESS_WIDTH-1 -: TAG_WIDTH];
  assign word_offset = address[BYTE_OFFSET_WIDTH +: WORD_OFFSET_WIDTH];
  assign byte_offset = address[0 +: BYTE_OFFSET_WIDTH];

  // Compare against every stored tag, invalid lines never match
  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
    begin
      match[i] = valid_lines[i] && (stored_tags[i] == tag);
    end
  end

  assign lookup_hit = |match;

  // Priority encode, walking downward so the lowest match wins
  always_comb
  begin
    hit_line = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        hit_line = line_index_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* cache_pkg.sv */
// Data cache shared definitions
`default_nettype none

package cache_pkg;

  // Address and data widths
  localparam int ADDRESS_WIDTH = 32;
  localparam int WORD_WIDTH = 32;

  // Line geometry
  localparam int NUM_LINES = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_WIDTH = WORDS_PER_LINE * WORD_WIDTH;

  // Address split, tag sits above the line offset
  localparam int BYTE_OFFSET_WIDTH = 2;
  localparam int WORD_OFFSET_WIDTH = 2;
  localparam int TAG_WIDTH = ADDRESS_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFFSET_WIDTH;
  localparam int LINE_INDEX_WIDTH = 2;

  // Encodings of the op input
  localparam logic OP_WRITE = 1'b0;
  localparam logic OP_READ = 1'b1;

  typedef logic [ADDRESS_WIDTH-1:0] address_t;
  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [LINE_INDEX_WIDTH-1:0] line_index_t;
  typedef logic [WORD_OFFSET_WIDTH-1:0] word_offset_t;
  typedef logic [BYTE_OFFSET_WIDTH-1:0] byte_offset_t;
  // One LRU age per line, highest is most recent
  typedef logic [LINE_INDEX_WIDTH-1:0] lru_count_t;

  // Controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    UPDATE,
    RESPOND
  } cache_state_t;

endpackage

`default_nettype wire
